/* flist.f */
+incdir+verilog
verilog/nvio_pkg.sv
verilog/bundle_buffer.sv
verilog/fetch_ctrl.sv
verilog/queue_credit.sv
verilog/slot_valid.sv
verilog/slot_enqueue.sv
verilog/insn_queue.sv
verilog/front_end_top.sv
bench/tb_front_end.sv

/* run_sim.sh */
#!/bin/sh
# build the front end testbench with Verilator and run it
# exit status is nonzero when the build fails or the run ends in $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps \
	--top-module tb_front_end -Mdir obj_dir -o tb_front_end \
	-f flist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_front_end
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

exit 0

/* bench/tb_front_end.sv */
`timescale 1ns/10ps
`include "nvio_defs.svh"

module tb_front_end;
	import nvio_pkg::*;

	// bundles pushed in each phase
	localparam int N_PLAIN = 100;
	localparam int N_MIXED = 150;
	localparam int N_BP = 12;
	localparam int N_PRE_FLUSH = 40;
	localparam int N_POST_FLUSH = 80;
	localparam int N_BUNDLES = N_PLAIN + N_MIXED + N_BP + N_PRE_FLUSH + N_POST_FLUSH;
	localparam real WATCHDOG_NS = 40.0 * (N_BUNDLES * 20 + 2000);

	logic clk;
	logic rst;
	logic bundle_push;
	slot_mask_t bundle_mask;
	slot_mask_t bundle_jc;
	slot_mask_t bundle_ret;
	slot_mask_t bundle_tb;
	logic bundle_override;
	slot_word_t [`NV_QSLOTS-1:0] bundle_insn;
	logic bundle_full;
	logic branchmiss;
	logic iq_pop;
	logic iq_valid;
	slot_word_t iq_insn;

	// expected words, oldest first
	slot_word_t exp_q [$];
	// next pushed bundle is dropped whole
	logic exp_stomp;
	logic [31:0] rng;
	int k;
	logic p;

	front_end_top dut (
		.clk, .rst, .bundle_push, .bundle_mask, .bundle_jc, .bundle_ret, .bundle_tb,
		.bundle_override, .bundle_insn, .bundle_full, .branchmiss, .iq_pop,
		.iq_valid, .iq_insn
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

	// ======================================================================
	// helpers
	// ======================================================================
	function automatic logic [31:0] rand_next();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expv,
			input logic [31:0] gotv);
		assert (gotv === expv) else begin
			$display("ERR %0t %s expected %0h observed %0h", $time, name, expv, gotv);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond) else begin
			$display("%0t %s", $time, msg);
			$display("Simulation FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// masked slots go in slot order and stop at the first redirecting slot
	// under override, which also stomps the next bundle
	task automatic model_push(input slot_mask_t m, input slot_mask_t jc,
			input slot_mask_t ret, input slot_mask_t tb, input logic ovr,
			input slot_word_t [`NV_QSLOTS-1:0] w);
		int cut;
		cut = `NV_QSLOTS;
		if (exp_stomp) begin
			exp_stomp = 1'b0;
		end else begin
			for (int i = `NV_QSLOTS - 1; i >= 0; i--) begin
				if (ovr && m[i] && (jc[i] || ret[i] || tb[i])) begin
					cut = i;
				end
			end
			for (int i = 0; i < `NV_QSLOTS; i++) begin
				if (m[i] && (i <= cut)) begin
					exp_q.push_back(w[i]);
				end
			end
			exp_stomp = (cut < `NV_QSLOTS);
		end
	endtask

	task automatic drive_bundle(input logic allow_ovr, input logic full_mask);
		logic [31:0] r;
		logic [31:0] s;
		r = rand_next();
		s = rand_next();
		bundle_mask = full_mask ? 3'b111 : r[2:0];
		// sparse flags with about one slot in four each
		bundle_jc = r[5:3] & r[8:6];
		bundle_ret = r[11:9] & r[14:12];
		bundle_tb = r[17:15] & r[20:18];
		bundle_override = allow_ovr & r[21] & r[22];
		bundle_insn[0] = s[15:0];
		bundle_insn[1] = s[31:16];
		bundle_insn[2] = r[31:16];
		bundle_push = 1'b1;
		model_push(bundle_mask, bundle_jc, bundle_ret, bundle_tb, bundle_override,
			bundle_insn);
	endtask

	// one cycle with inputs set on the falling edge
	// pop_thr out of 256 is the chance of popping a valid head
	task automatic step(input logic push_en, input logic allow_ovr, input logic full_mask,
			input int pop_thr, output logic pushed_now);
		logic [31:0] r;
		slot_word_t head;
		@(negedge clk);
		bundle_push = 1'b0;
		iq_pop = 1'b0;
		pushed_now = 1'b0;
		r = rand_next();
		if (iq_valid && (int'(r[7:0]) < pop_thr)) begin
			check_true(exp_q.size() != 0, "queue presented an instruction none was expected");
			head = exp_q.pop_front();
			check_value("iq_insn", 32'(head), 32'(iq_insn));
			iq_pop = 1'b1;
		end
		if (push_en && !bundle_full && r[8]) begin
			drive_bundle(allow_ovr, full_mask);
			pushed_now = 1'b1;
		end
	endtask

	task automatic run_bundles(input int n, input logic allow_ovr, input int pop_thr);
		int done;
		logic pushed_now;
		done = 0;
		while (done < n) begin
			step(1'b1, allow_ovr, 1'b0, pop_thr, pushed_now);
			if (pushed_now) begin
				done++;
			end
		end
	endtask

	// pop everything and then expect nothing more
	task automatic drain_all();
		logic pushed_now;
		while (exp_q.size() != 0) begin
			step(1'b0, 1'b0, 1'b0, 256, pushed_now);
		end
		repeat (10) begin
			@(negedge clk);
			bundle_push = 1'b0;
			iq_pop = 1'b0;
			check_value("iq_valid", 32'(1'b0), 32'(iq_valid));
		end
	endtask

	// full bundles with no pops until the buffer reports full
	task automatic fill_and_drain();
		int n;
		int cyc;
		logic pushed_now;
		n = 0;
		cyc = 0;
		while (!bundle_full && (cyc < N_BP + 20)) begin
			step(n < N_BP, 1'b0, 1'b1, 0, pushed_now);
			if (pushed_now) begin
				n++;
			end
			cyc++;
		end
		check_true(bundle_full, "bundle buffer did not fill while pops were held off");
		drain_all();
	endtask

	// branchmiss with no push or pop around it and a fresh model
	task automatic flush_pulse();
		@(negedge clk);
		bundle_push = 1'b0;
		iq_pop = 1'b0;
		branchmiss = 1'b1;
		exp_q.delete();
		exp_stomp = 1'b0;
		@(negedge clk);
		branchmiss = 1'b0;
		@(negedge clk);
		check_value("iq_valid", 32'(1'b0), 32'(iq_valid));
	endtask

	// ======================================================================
	// test sequence
	// ======================================================================
	initial begin
		rng = 32'd20041;
		exp_stomp = 1'b0;
		rst = 1'b1;
		bundle_push = 1'b0;
		bundle_mask = '0;
		bundle_jc = '0;
		bundle_ret = '0;
		bundle_tb = '0;
		bundle_override = 1'b0;
		bundle_insn = '0;
		branchmiss = 1'b0;
		iq_pop = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_value("iq_valid", 32'(1'b0), 32'(iq_valid));
		check_value("bundle_full", 32'(1'b0), 32'(bundle_full));

		// flags without override drop nothing
		run_bundles(N_PLAIN, 1'b0, 192);
		drain_all();
		// overrides mixed in
		run_bundles(N_MIXED, 1'b1, 160);
		fill_and_drain();

		// flush at a random point in the stream
		k = 20 + int'(rand_next() % 20);
		run_bundles(k, 1'b1, 160);
		k = int'(rand_next() % 6);
		repeat (k) step(1'b0, 1'b1, 1'b0, 160, p);
		flush_pulse();
		run_bundles(N_POST_FLUSH, 1'b1, 160);
		drain_all();

		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* verilog/front_end_top.sv */
`timescale 1ns/10ps
`include "nvio_defs.svh"

module front_end_top (
	input  logic clk,
	input  logic rst,
	input  logic bundle_push,
	input  nvio_pkg::slot_mask_t bundle_mask,
	input  nvio_pkg::slot_mask_t bundle_jc,
	input  nvio_pkg::slot_mask_t bundle_ret,
	input  nvio_pkg::slot_mask_t bundle_tb,
	input  logic bundle_override,
	input  nvio_pkg::slot_word_t [`NV_QSLOTS-1:0] bundle_insn,
	output logic bundle_full,
	input  logic branchmiss,
	input  logic iq_pop,
	output logic iq_valid,
	output nvio_pkg::slot_word_t iq_insn
);
	import nvio_pkg::*;

	localparam int IQ_PTR_W = $clog2(`NV_IQ_DEPTH);

	logic flush;
	logic nextb;
	logic buf_empty;
	logic slot_done;
	// head of the bundle buffer
	slot_mask_t head_mask, head_jc, head_ret, head_tb;
	logic head_override;
	slot_word_t [`NV_QSLOTS-1:0] head_insn;
	// bundle being queued
	slot_mask_t cur_jc, cur_ret, cur_tb;
	logic cur_override;
	slot_word_t [`NV_QSLOTS-1:0] cur_insn;
	// enqueue path
	slot_mask_t slot_live;
	qcnt_t wr_cnt;
	logic [`NV_QSLOTS-1:0] wr_en;
	slot_word_t [`NV_QSLOTS-1:0] wr_data;
	logic [IQ_PTR_W-1:0] wr_ptr, rd_ptr;
	iq_cnt_t iq_free;

	// ======================================================================
	// current bundle register, loaded with the buffer head on nextb
	// ======================================================================
	always_ff @(posedge clk) begin
		if (nextb) begin
			cur_jc <= head_jc;
			cur_ret <= head_ret;
			cur_tb <= head_tb;
			cur_override <= head_override;
			cur_insn <= head_insn;
		end
	end

	bundle_buffer u_buf (
		.clk, .rst, .flush, .push(bundle_push),
		.in_mask(bundle_mask), .in_jc(bundle_jc), .in_ret(bundle_ret), .in_tb(bundle_tb),
		.in_override(bundle_override), .in_insn(bundle_insn), .pop(nextb),
		.out_mask(head_mask), .out_jc(head_jc), .out_ret(head_ret), .out_tb(head_tb),
		.out_override(head_override), .out_insn(head_insn),
		.full(bundle_full), .empty(buf_empty)
	);

	fetch_ctrl u_ctrl (
		.clk, .rst, .branchmiss, .buf_empty, .slot_done, .nextb, .flush
	);

	slot_valid u_slotv (
		.clk, .rst, .flush, .nextb, .ip_mask(head_mask),
		.slot_jc(cur_jc), .slot_ret(cur_ret), .take_branch(cur_tb),
		.ip_override(cur_override), .queued_cnt(wr_cnt), .slot_live, .slot_done
	);

	slot_enqueue u_enq (
		.slot_live, .slot_insn(cur_insn), .iq_free, .wr_en, .wr_data, .wr_cnt
	);

	// queue pops come straight from the consumer
	queue_credit u_credit (
		.clk, .rst, .flush, .wr_cnt, .rd(iq_pop), .wr_ptr, .rd_ptr, .iq_free,
		.iq_nonempty(iq_valid)
	);

	insn_queue u_iq (
		.clk, .wr_en, .wr_data, .wr_ptr, .rd_ptr, .iq_insn
	);

endmodule

/* verilog/insn_queue.sv */
`timescale 1ns/10ps
`include "nvio_defs.svh"

module insn_queue (
	input  logic clk,
	input  logic [`NV_QSLOTS-1:0] wr_en,
	input  nvio_pkg::slot_word_t [`NV_QSLOTS-1:0] wr_data,
	input  logic [$clog2(`NV_IQ_DEPTH)-1:0] wr_ptr,
	input  logic [$clog2(`NV_IQ_DEPTH)-1:0] rd_ptr,
	output nvio_pkg::slot_word_t iq_insn
);
	import nvio_pkg::*;

	localparam int PTR_W = $clog2(`NV_IQ_DEPTH);

	slot_word_t mem [`NV_IQ_DEPTH];

	// lane k writes k entries past the write pointer
	// lanes are packed from 0 so enabled lanes are contiguous
	always_ff @(posedge clk) begin
		logic [PTR_W-1:0] addr;
		for (int k = 0; k < `NV_QSLOTS; k++) begin
			addr = wr_ptr + PTR_W'(k);
			if (wr_en[k]) begin
				mem[addr] <= wr_data[k];
			end
		end
	end

	// head word, valid whenever the queue holds something
	assign iq_insn = mem[rd_ptr];

endmodule

/* verilog/slot_enqueue.sv */
`timescale 1ns/10ps
`include "nvio_defs.svh"

module slot_enqueue (
	input  nvio_pkg::slot_mask_t slot_live,
	input  nvio_pkg::slot_word_t [`NV_QSLOTS-1:0] slot_insn,
	input  nvio_pkg::iq_cnt_t iq_free,
	output logic [`NV_QSLOTS-1:0] wr_en,
	output nvio_pkg::slot_word_t [`NV_QSLOTS-1:0] wr_data,
	output nvio_pkg::qcnt_t wr_cnt
);
	import nvio_pkg::*;

	qcnt_t live_cnt;

	// count live slots
	always_comb begin
		live_cnt = '0;
		for (int i = 0; i < `NV_QSLOTS; i++) begin
			live_cnt = live_cnt + qcnt_t'(slot_live[i]);
		end
	end

	// never write more than the queue has room for
	assign wr_cnt = (iq_cnt_t'(live_cnt) > iq_free) ? qcnt_t'(iq_free) : live_cnt;

	// lowest live slots go to lanes 0 upward, slot order kept
	always_comb begin
		qcnt_t lane;
		lane = '0;
		wr_en = '0;
		wr_data = '0;
		for (int i = 0; i < `NV_QSLOTS; i++) begin
			if (slot_live[i] && (lane < wr_cnt)) begin
				wr_en[lane] = 1'b1;
				wr_data[lane] = slot_insn[i];
				lane = lane + 1'b1;
			end
		end
	end

endmodule

/* verilog/slot_valid.sv */
`timescale 1ns/10ps
`include "nvio_defs.svh"

module slot_valid (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  logic nextb,
	input  nvio_pkg::slot_mask_t ip_mask,
	input  nvio_pkg::slot_mask_t slot_jc,
	input  nvio_pkg::slot_mask_t slot_ret,
	input  nvio_pkg::slot_mask_t take_branch,
	input  logic ip_override,
	input  nvio_pkg::qcnt_t queued_cnt,
	output nvio_pkg::slot_mask_t slot_live,
	output logic slot_done
);
	import nvio_pkg::*;

	// slots of the current bundle not yet queued
	slot_mask_t pend;
	// drop the whole next bundle on its load
	logic stomp;

	slot_mask_t redir;
	slot_mask_t retire;
	slot_mask_t remain;
	logic stomp_set;

	// ======================================================================
	// redirect detection
	// ======================================================================
	// a pending slot redirects when it is a jump, return or taken branch
	// and the predictor overrides fetch for this bundle
	assign redir = (slot_jc | slot_ret | take_branch) & {`NV_QSLOTS{ip_override}} & pend;

	// nothing past the first redirecting slot is live
	always_comb begin
		if (redir[0]) begin
			slot_live = pend & slot_mask_t'(3'b001);
		end else if (redir[1]) begin
			slot_live = pend & slot_mask_t'(3'b011);
		end else begin
			slot_live = pend;
		end
	end

	// ======================================================================
	// retirement
	// ======================================================================
	// enqueue takes the lowest live slots first, queued_cnt of them
	always_comb begin
		qcnt_t taken;
		taken = '0;
		retire = '0;
		for (int i = 0; i < `NV_QSLOTS; i++) begin
			if (slot_live[i] && (taken < queued_cnt)) begin
				retire[i] = 1'b1;
				taken = taken + 1'b1;
			end
		end
	end

	assign remain = slot_live & ~retire;
	assign slot_done = (remain == '0);

	// redirecting slot is the highest live one
	// so it has gone once nothing live remains
	assign stomp_set = (redir != '0) & slot_done;

	always_ff @(posedge clk) begin
		if (rst | flush) begin
			pend <= '0;
			stomp <= 1'b0;
		end else if (nextb) begin
			// stomp may be set by the retirement in this very cycle
			pend <= (stomp | stomp_set) ? '0 : ip_mask;
			stomp <= 1'b0;
		end else begin
			// slots cut after a redirect are dropped here too
			pend <= remain;
			stomp <= stomp | stomp_set;
		end
	end

endmodule

/* verilog/queue_credit.sv */
`timescale 1ns/10ps
`include "nvio_defs.svh"

module queue_credit (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  nvio_pkg::qcnt_t wr_cnt,
	input  logic rd,
	output logic [$clog2(`NV_IQ_DEPTH)-1:0] wr_ptr,
	output logic [$clog2(`NV_IQ_DEPTH)-1:0] rd_ptr,
	output nvio_pkg::iq_cnt_t iq_free,
	output logic iq_nonempty
);
	import nvio_pkg::*;

	localparam int PTR_W = $clog2(`NV_IQ_DEPTH);

	iq_cnt_t count;
	logic rd_ok;

	// a pop on an empty queue is dropped
	assign rd_ok = rd & iq_nonempty;
	assign iq_nonempty = (count != '0);
	// free entries bound how many slots may be written this cycle
	assign iq_free = iq_cnt_t'(`NV_IQ_DEPTH) - count;

	always_ff @(posedge clk) begin
		if (rst | flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// up to three writes land at wr_ptr onward
			wr_ptr <= wr_ptr + PTR_W'(wr_cnt);
			rd_ptr <= rd_ptr + PTR_W'(rd_ok);
			count <= count + iq_cnt_t'(wr_cnt) - iq_cnt_t'(rd_ok);
		end
	end

endmodule

/* verilog/fetch_ctrl.sv */
`timescale 1ns/10ps

module fetch_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic branchmiss,
	input  logic buf_empty,
	input  logic slot_done,
	output logic nextb,
	output logic flush
);

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		RUN   = 2'd1,
		FLUSH = 2'd2
	} state_t;

	state_t state;
	state_t state_nxt;

	// clear on the edge after branchmiss and hold clear through FLUSH
	assign flush = branchmiss | (state == FLUSH);

	// next bundle goes in once the current one has nothing left to queue
	// never while the front end is being cleared
	assign nextb = ~flush & slot_done & ~buf_empty;

	always_comb begin
		state_nxt = state;
		if (branchmiss) begin
			state_nxt = FLUSH;
		end else begin
			case (state)
				IDLE: begin
					if (nextb) begin
						state_nxt = RUN;
					end
				end
				RUN: begin
					// last slots gone and nothing buffered behind them
					if (slot_done & buf_empty) begin
						state_nxt = IDLE;
					end
				end
				default: begin
					state_nxt = IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

/* verilog/bundle_buffer.sv */
`timescale 1ns/10ps
`include "nvio_defs.svh"

module bundle_buffer (
	input  logic clk,
	input  logic rst,
	input  logic flush,
	input  logic push,
	input  nvio_pkg::slot_mask_t in_mask,
	input  nvio_pkg::slot_mask_t in_jc,
	input  nvio_pkg::slot_mask_t in_ret,
	input  nvio_pkg::slot_mask_t in_tb,
	input  logic in_override,
	input  nvio_pkg::slot_word_t [`NV_QSLOTS-1:0] in_insn,
	input  logic pop,
	output nvio_pkg::slot_mask_t out_mask,
	output nvio_pkg::slot_mask_t out_jc,
	output nvio_pkg::slot_mask_t out_ret,
	output nvio_pkg::slot_mask_t out_tb,
	output logic out_override,
	output nvio_pkg::slot_word_t [`NV_QSLOTS-1:0] out_insn,
	output logic full,
	output logic empty
);
	import nvio_pkg::*;

	localparam int PTR_W = $clog2(`NV_BUF_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	// ======================================================================
	// bundle storage, one entry per field
	// ======================================================================
	slot_mask_t mask_mem [`NV_BUF_DEPTH];
	slot_mask_t jc_mem [`NV_BUF_DEPTH];
	slot_mask_t ret_mem [`NV_BUF_DEPTH];
	slot_mask_t tb_mem [`NV_BUF_DEPTH];
	logic ovr_mem [`NV_BUF_DEPTH];
	slot_word_t [`NV_QSLOTS-1:0] insn_mem [`NV_BUF_DEPTH];

	logic [PTR_W-1:0] wp;
	logic [PTR_W-1:0] rp;
	logic [PTR_W-1:0] wr_idx;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == CNT_W'(`NV_BUF_DEPTH));
	assign empty = (count == '0);

	// a push during flush lands in the emptied buffer at entry 0
	assign do_push = push & (flush | ~full);
	assign do_pop = pop & ~empty & ~flush;
	assign wr_idx = flush ? '0 : wp;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mask_mem[wr_idx] <= in_mask;
			jc_mem[wr_idx] <= in_jc;
			ret_mem[wr_idx] <= in_ret;
			tb_mem[wr_idx] <= in_tb;
			ovr_mem[wr_idx] <= in_override;
			insn_mem[wr_idx] <= in_insn;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wp <= '0;
			rp <= '0;
			count <= '0;
		end else if (flush) begin
			wp <= PTR_W'(do_push);
			rp <= '0;
			count <= CNT_W'(do_push);
		end else begin
			wp <= wp + PTR_W'(do_push);
			rp <= rp + PTR_W'(do_pop);
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	// head bundle straight out of storage
	assign out_mask = mask_mem[rp];
	assign out_jc = jc_mem[rp];
	assign out_ret = ret_mem[rp];
	assign out_tb = tb_mem[rp];
	assign out_override = ovr_mem[rp];
	assign out_insn = insn_mem[rp];

endmodule

/* verilog/nvio_pkg.sv */
`include "nvio_defs.svh"

package nvio_pkg;

	// one bit per slot of a bundle
	// used for the valid mask and for each control-flow flag
	typedef logic [`NV_QSLOTS-1:0] slot_mask_t;

	// one queued instruction
	typedef logic [`NV_SLOT_W-1:0] slot_word_t;

	// number of slots moved in one cycle, 0 up to a full bundle
	typedef logic [$clog2(`NV_QSLOTS+1)-1:0] qcnt_t;

	// instruction queue occupancy or free space, 0 up to the depth
	typedef logic [$clog2(`NV_IQ_DEPTH+1)-1:0] iq_cnt_t;

endpackage

/* verilog/nvio_defs.svh */
`ifndef NVIO_DEFS_SVH
`define NVIO_DEFS_SVH

// slots in one fetched bundle
// the slot tracker's cut logic is written for exactly three
`define NV_QSLOTS 3
// bits in one instruction slot
`define NV_SLOT_W 16
// bundles held between fetch and the slot tracker
`define NV_BUF_DEPTH 4
// instruction queue entries, a power of two so pointers wrap
`define NV_IQ_DEPTH 8

`endif
